// ==== common/rv_pkg.sv ====
// shared widths, opcodes and select encodings for the RV32I core
// only the opcodes and funct codes of the supported subset are listed
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // --------------------------------------------------------------------------
  // opcodes
  // --------------------------------------------------------------------------
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

  // funct3 of alu operations
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // lw and sw only
  localparam logic [2:0] f3_word    = 3'b010;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // --------------------------------------------------------------------------
  // select encodings
  // --------------------------------------------------------------------------
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_func_t;

  typedef enum logic {opa_rs1, opa_pc} opa_sel_t;
  typedef enum logic {opb_rs2, opb_imm} opb_sel_t;

  typedef enum logic [2:0] {wb_alu, wb_mem, wb_pc_plus_4, wb_imm} wb_sel_t;

  typedef enum logic [1:0] {
    next_pc_plus_4, next_pc_plus_imm, next_pc_alu_target
  } next_pc_sel_t;

  localparam word_t initial_pc = '0;

endpackage

// ==== common/ctrl_if.sv ====
// control unit to data path link
// control drives selects and enables, data path returns decoded fields
`timescale 1ns/1ps

interface ctrl_if;
  import rv_pkg::*;

  logic         pc_write_enable;
  logic         regfile_write_enable;
  opa_sel_t     alu_operand_a_select;
  opb_sel_t     alu_operand_b_select;
  wb_sel_t      reg_writeback_select;
  next_pc_sel_t next_pc_select;
  alu_func_t    alu_function;

  opcode_t      inst_opcode;
  logic [2:0]   inst_funct3;
  logic [6:0]   inst_funct7;
  logic         alu_result_equal_zero;

  modport control (
    output pc_write_enable, regfile_write_enable, alu_operand_a_select,
           alu_operand_b_select, reg_writeback_select, next_pc_select, alu_function,
    input  inst_opcode, inst_funct3, inst_funct7, alu_result_equal_zero
  );

  modport datapath (
    input  pc_write_enable, regfile_write_enable, alu_operand_a_select,
           alu_operand_b_select, reg_writeback_select, next_pc_select, alu_function,
    output inst_opcode, inst_funct3, inst_funct7, alu_result_equal_zero
  );
endinterface

// ==== rtl/alu.sv ====
// combinational RV32I ALU
// shift amount comes from operand_b[4:0]
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_func_t alu_function,
  input  rv_pkg::word_t     operand_a,
  input  rv_pkg::word_t     operand_b,
  output rv_pkg::word_t     result,
  output logic              result_equal_zero
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin : compute
    case (alu_function)
      alu_add:    result = operand_a + operand_b;
      alu_sub:    result = operand_a - operand_b;
      alu_sll:    result = operand_a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, operand_a < operand_b};
      alu_xor:    result = operand_a ^ operand_b;
      alu_srl:    result = operand_a >> shamt;
      // arithmetic shift keeps the sign bit
      alu_sra:    result = word_t'($signed(operand_a) >>> shamt);
      alu_or:     result = operand_a | operand_b;
      alu_and:    result = operand_a & operand_b;
      alu_pass_b: result = operand_b;
      default:    result = '0;
    endcase
  end

  // used by control for branch decisions
  assign result_equal_zero = (result == '0);

endmodule

// ==== rtl/regfile.sv ====
// 32 x 32 register file, two async read ports, one sync write port
// x0 reads as zero and ignores writes
`timescale 1ns/1ps

module regfile (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              write_enable,
  input  rv_pkg::reg_addr_t rd_address,
  input  rv_pkg::reg_addr_t rs1_address,
  input  rv_pkg::reg_addr_t rs2_address,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd_address != '0) begin
      regs[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

// ==== rtl/immediate_generator.sv ====
// immediate formats of RV32I, sign extended to 32 bits
// R-type and unknown opcodes give zero
`timescale 1ns/1ps

module immediate_generator (
  input  rv_pkg::word_t inst,
  output rv_pkg::word_t immediate
);
  import rv_pkg::*;

  always_comb begin : select_format
    case (opcode_t'(inst[6:0]))
      op_imm, op_load, op_jalr:
        immediate = {{20{inst[31]}}, inst[31:20]};
      op_store:
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      op_branch:
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      op_lui, op_auipc:
        immediate = {inst[31:12], 12'b0};
      op_jal:
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

// ==== singlecycle_datapath/singlecycle_datapath.sv ====
// single-cycle RV32I data path
// PC holds while pc_write_enable is low; memory address is the ALU result
`timescale 1ns/1ps

module singlecycle_datapath (
  input  logic              clock,
  input  logic              arst_n,
  ctrl_if.datapath          ctrl,
  input  rv_pkg::word_t     inst,
  input  rv_pkg::word_t     data_mem_read_data,
  output rv_pkg::word_t     data_mem_address,
  output rv_pkg::word_t     data_mem_write_data,
  output rv_pkg::word_t     pc,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  reg_addr_t inst_rs1;
  reg_addr_t inst_rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     immediate;
  word_t     operand_a;
  word_t     operand_b;
  word_t     alu_result;
  word_t     pc_plus_4;
  word_t     pc_plus_imm;
  word_t     alu_target;
  word_t     next_pc;
  word_t     wb_data;

  // instruction fields
  assign ctrl.inst_opcode = inst[6:0];
  assign ctrl.inst_funct3 = inst[14:12];
  assign ctrl.inst_funct7 = inst[31:25];
  assign rd               = inst[11:7];
  assign inst_rs1         = inst[19:15];
  assign inst_rs2         = inst[24:20];

  regfile regs (
    .clock        (clock),
    .arst_n       (arst_n),
    .write_enable (ctrl.regfile_write_enable),
    .rd_address   (rd),
    .rs1_address  (inst_rs1),
    .rs2_address  (inst_rs2),
    .rd_data      (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  immediate_generator igen (
    .inst      (inst),
    .immediate (immediate)
  );

  assign operand_a = (ctrl.alu_operand_a_select == opa_pc) ? pc : rs1_data;
  assign operand_b = (ctrl.alu_operand_b_select == opb_imm) ? immediate : rs2_data;

  alu alu_core (
    .alu_function      (ctrl.alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (ctrl.alu_result_equal_zero)
  );

  // ------------------------------------------------------------------------
  // next pc
  // ------------------------------------------------------------------------
  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + immediate;
  // jalr clears bit 0
  assign alu_target  = {alu_result[xlen-1:1], 1'b0};

  always_comb begin : next_pc_mux
    case (ctrl.next_pc_select)
      next_pc_plus_imm:   next_pc = pc_plus_imm;
      next_pc_alu_target: next_pc = alu_target;
      default:            next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= initial_pc;
    end else if (ctrl.pc_write_enable) begin
      pc <= next_pc;
    end
  end

  always_comb begin : writeback_mux
    case (ctrl.reg_writeback_select)
      wb_mem:       wb_data = data_mem_read_data;
      wb_pc_plus_4: wb_data = pc_plus_4;
      wb_imm:       wb_data = immediate;
      default:      wb_data = alu_result;
    endcase
  end

  assign rd_data             = wb_data;
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

endmodule

// ==== rtl/singlecycle_control.sv ====
// decoder for the supported RV32I subset
// unsupported encodings retire as no-ops; stall blocks every state update
`timescale 1ns/1ps

module singlecycle_control (
  input  logic    stall,
  ctrl_if.control ctrl,
  output logic    data_mem_write_enable
);
  import rv_pkg::*;

  logic reg_write;
  logic mem_write;
  logic branch_taken;
  logic imm_valid;
  logic reg_valid;

  function automatic alu_func_t alu_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      f3_add_sub: alu_op = alt ? alu_sub : alu_add;
      f3_sll:     alu_op = alu_sll;
      f3_slt:     alu_op = alu_slt;
      f3_sltu:    alu_op = alu_sltu;
      f3_xor:     alu_op = alu_xor;
      f3_srl_sra: alu_op = alt ? alu_sra : alu_srl;
      f3_or:      alu_op = alu_or;
      f3_and:     alu_op = alu_and;
      default:    alu_op = alu_add;
    endcase
  endfunction

  // beq/bge/bgeu want zero, the others want nonzero
  assign branch_taken = ctrl.alu_result_equal_zero ^ ctrl.inst_funct3[0]
                        ^ ctrl.inst_funct3[2];

  assign imm_valid = (ctrl.inst_funct3 == f3_sll)     ? (ctrl.inst_funct7 == f7_base) :
                     (ctrl.inst_funct3 == f3_srl_sra) ? (ctrl.inst_funct7 == f7_base ||
                                                         ctrl.inst_funct7 == f7_alt) :
                     1'b1;
  assign reg_valid = (ctrl.inst_funct7 == f7_base) ||
                     (ctrl.inst_funct7 == f7_alt && (ctrl.inst_funct3 == f3_add_sub ||
                                                     ctrl.inst_funct3 == f3_srl_sra));

  always_comb begin : decode
    reg_write                 = 1'b0;
    mem_write                 = 1'b0;
    ctrl.alu_operand_a_select = opa_rs1;
    ctrl.alu_operand_b_select = opb_imm;
    ctrl.reg_writeback_select = wb_alu;
    ctrl.next_pc_select       = next_pc_plus_4;
    ctrl.alu_function         = alu_add;
    case (ctrl.inst_opcode)
      op_lui: begin
        reg_write                 = 1'b1;
        ctrl.alu_function         = alu_pass_b;
        ctrl.reg_writeback_select = wb_imm;
      end
      op_auipc: begin
        reg_write                 = 1'b1;
        ctrl.alu_operand_a_select = opa_pc;
      end
      op_jal: begin
        reg_write                 = 1'b1;
        ctrl.reg_writeback_select = wb_pc_plus_4;
        ctrl.next_pc_select       = next_pc_plus_imm;
      end
      op_jalr: begin
        if (ctrl.inst_funct3 == 3'b000) begin
          reg_write                 = 1'b1;
          ctrl.reg_writeback_select = wb_pc_plus_4;
          ctrl.next_pc_select       = next_pc_alu_target;
        end
      end
      op_branch: begin
        ctrl.alu_operand_b_select = opb_rs2;
        // funct3 010 and 011 are not branches
        if (ctrl.inst_funct3[2:1] != 2'b01) begin
          if (!ctrl.inst_funct3[2]) begin
            ctrl.alu_function = alu_sub;
          end else begin
            ctrl.alu_function = ctrl.inst_funct3[1] ? alu_sltu : alu_slt;
          end
          if (branch_taken) begin
            ctrl.next_pc_select = next_pc_plus_imm;
          end
        end
      end
      op_load: begin
        reg_write                 = (ctrl.inst_funct3 == f3_word);
        ctrl.reg_writeback_select = wb_mem;
      end
      op_store: begin
        mem_write = (ctrl.inst_funct3 == f3_word);
      end
      op_imm: begin
        reg_write         = imm_valid;
        ctrl.alu_function = alu_op(ctrl.inst_funct3,
                                   ctrl.inst_funct3 == f3_srl_sra && ctrl.inst_funct7[5]);
      end
      op_reg: begin
        reg_write                 = reg_valid;
        ctrl.alu_operand_b_select = opb_rs2;
        ctrl.alu_function         = alu_op(ctrl.inst_funct3, ctrl.inst_funct7[5]);
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

  assign ctrl.pc_write_enable      = !stall;
  assign ctrl.regfile_write_enable = reg_write && !stall;
  assign data_mem_write_enable     = mem_write && !stall;

endmodule

// ==== rtl/simple_rv_core.sv ====
// single-cycle RV32I core, one instruction per clock edge unless stalled
// fetch and data memory reads are combinational; retire_valid follows
// stall only, so qualify it with arst_n while in reset
`timescale 1ns/1ps

module simple_rv_core (
  input  logic              clock,
  input  logic              arst_n,
  output rv_pkg::word_t     inst_address,
  input  rv_pkg::word_t     inst,
  output rv_pkg::word_t     data_mem_address,
  output rv_pkg::word_t     data_mem_write_data,
  output logic              data_mem_write_enable,
  input  rv_pkg::word_t     data_mem_read_data,
  input  logic              stall,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output logic              retire_rd_write,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_rd_data
);

  ctrl_if ctrl ();

  singlecycle_control control (
    .stall                 (stall),
    .ctrl                  (ctrl.control),
    .data_mem_write_enable (data_mem_write_enable)
  );

  singlecycle_datapath datapath (
    .clock               (clock),
    .arst_n              (arst_n),
    .ctrl                (ctrl.datapath),
    .inst                (inst),
    .data_mem_read_data  (data_mem_read_data),
    .data_mem_address    (data_mem_address),
    .data_mem_write_data (data_mem_write_data),
    .pc                  (inst_address),
    .rd                  (retire_rd),
    .rd_data             (retire_rd_data)
  );

  // retire port
  assign retire_valid    = ctrl.pc_write_enable;
  assign retire_pc       = inst_address;
  assign retire_rd_write = ctrl.regfile_write_enable;

endmodule

// ==== verif/tb_program.svh ====
// program for the core testbench, listed in execution order without loops
// branch targets that are skipped over have no entry
// columns: pc, instruction, rd written, rd, rd value, next pc
// rd and rd value are only checked where rd is written
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

task automatic load_program;
  // upper immediates, then register-immediate operations
  add_entry(32'h00, u_type(20'h80000, 5'd1, op_lui), 1'b1, 5'd1, 32'h8000_0000, 32'h04);
  add_entry(32'h04, u_type(20'h00001, 5'd2, op_auipc), 1'b1, 5'd2, 32'h0000_1004, 32'h08);
  add_entry(32'h08, i_type(12'hFF8, 5'd0, 3'b000, 5'd3, op_imm), 1'b1, 5'd3, 32'hFFFF_FFF8, 32'h0C);
  add_entry(32'h0C, i_type(12'h401, 5'd3, 3'b101, 5'd4, op_imm), 1'b1, 5'd4, 32'hFFFF_FFFC, 32'h10);
  add_entry(32'h10, i_type(12'h01C, 5'd3, 3'b101, 5'd5, op_imm), 1'b1, 5'd5, 32'h0000_000F, 32'h14);
  add_entry(32'h14, i_type(12'h005, 5'd3, 3'b011, 5'd6, op_imm), 1'b1, 5'd6, 32'h0000_0000, 32'h18);
  add_entry(32'h18, i_type(12'h005, 5'd3, 3'b010, 5'd7, op_imm), 1'b1, 5'd7, 32'h0000_0001, 32'h1C);
  add_entry(32'h1C, i_type(12'h0F0, 5'd3, 3'b100, 5'd8, op_imm), 1'b1, 5'd8, 32'hFFFF_FF08, 32'h20);
  add_entry(32'h20, i_type(12'h7FF, 5'd0, 3'b110, 5'd9, op_imm), 1'b1, 5'd9, 32'h0000_07FF, 32'h24);
  add_entry(32'h24, i_type(12'h0F0, 5'd9, 3'b111, 5'd10, op_imm), 1'b1, 5'd10, 32'h0000_00F0, 32'h28);
  add_entry(32'h28, i_type(12'h004, 5'd9, 3'b001, 5'd11, op_imm), 1'b1, 5'd11, 32'h0000_7FF0, 32'h2C);
  // register-register operations
  add_entry(32'h2C, r_type(f7_base, 5'd9, 5'd3, 3'b000, 5'd12), 1'b1, 5'd12, 32'h0000_07F7, 32'h30);
  add_entry(32'h30, r_type(f7_alt, 5'd3, 5'd9, 3'b000, 5'd13), 1'b1, 5'd13, 32'h0000_0807, 32'h34);
  add_entry(32'h34, r_type(f7_alt, 5'd5, 5'd1, 3'b101, 5'd14), 1'b1, 5'd14, 32'hFFFF_0000, 32'h38);
  add_entry(32'h38, r_type(f7_base, 5'd5, 5'd1, 3'b101, 5'd15), 1'b1, 5'd15, 32'h0001_0000, 32'h3C);
  add_entry(32'h3C, r_type(f7_base, 5'd9, 5'd3, 3'b011, 5'd16), 1'b1, 5'd16, 32'h0000_0000, 32'h40);
  add_entry(32'h40, r_type(f7_base, 5'd9, 5'd3, 3'b010, 5'd17), 1'b1, 5'd17, 32'h0000_0001, 32'h44);
  add_entry(32'h44, r_type(f7_base, 5'd7, 5'd9, 3'b001, 5'd18), 1'b1, 5'd18, 32'h0000_0FFE, 32'h48);
  add_entry(32'h48, r_type(f7_base, 5'd9, 5'd3, 3'b100, 5'd19), 1'b1, 5'd19, 32'hFFFF_F807, 32'h4C);
  add_entry(32'h4C, r_type(f7_base, 5'd7, 5'd10, 3'b110, 5'd20), 1'b1, 5'd20, 32'h0000_00F1, 32'h50);
  add_entry(32'h50, r_type(f7_base, 5'd9, 5'd3, 3'b111, 5'd21), 1'b1, 5'd21, 32'h0000_07F8, 32'h54);
  // store then load of word 2, then x0 written and read back
  add_entry(32'h54, s_type(12'h008, 5'd13, 5'd0), 1'b0, 5'd0, 32'h0, 32'h58);
  add_entry(32'h58, i_type(12'h008, 5'd0, 3'b010, 5'd22, op_load), 1'b1, 5'd22, 32'h0000_0807, 32'h5C);
  add_entry(32'h5C, i_type(12'h001, 5'd9, 3'b000, 5'd0, op_imm), 1'b1, 5'd0, 32'h0000_0800, 32'h60);
  add_entry(32'h60, r_type(f7_base, 5'd9, 5'd0, 3'b000, 5'd24), 1'b1, 5'd24, 32'h0000_07FF, 32'h64);
  // branches, taken then not taken
  add_entry(32'h64, b_type(13'd8, 5'd9, 5'd9, 3'b000), 1'b0, 5'd0, 32'h0, 32'h6C);
  add_entry(32'h6C, b_type(13'd8, 5'd10, 5'd9, 3'b000), 1'b0, 5'd0, 32'h0, 32'h70);
  add_entry(32'h70, b_type(13'd8, 5'd10, 5'd9, 3'b001), 1'b0, 5'd0, 32'h0, 32'h78);
  add_entry(32'h78, b_type(13'd8, 5'd9, 5'd9, 3'b001), 1'b0, 5'd0, 32'h0, 32'h7C);
  add_entry(32'h7C, b_type(13'd8, 5'd9, 5'd3, 3'b100), 1'b0, 5'd0, 32'h0, 32'h84);
  add_entry(32'h84, b_type(13'd8, 5'd3, 5'd9, 3'b100), 1'b0, 5'd0, 32'h0, 32'h88);
  add_entry(32'h88, b_type(13'd8, 5'd9, 5'd3, 3'b111), 1'b0, 5'd0, 32'h0, 32'h90);
  add_entry(32'h90, b_type(13'd8, 5'd3, 5'd9, 3'b111), 1'b0, 5'd0, 32'h0, 32'h94);
  // jal, then jalr to an odd target
  add_entry(32'h94, j_type(21'd12, 5'd25), 1'b1, 5'd25, 32'h0000_0098, 32'hA0);
  add_entry(32'hA0, i_type(12'h019, 5'd25, 3'b000, 5'd26, op_jalr), 1'b1, 5'd26, 32'h0000_00A4, 32'hB0);
  add_entry(32'hB0, i_type(12'h001, 5'd26, 3'b000, 5'd27, op_imm), 1'b1, 5'd27, 32'h0000_00A5, 32'hB4);
endtask

`endif

// ==== verif/simple_rv_core_tb.sv ====
// testbench for simple_rv_core, program and expected retire values in tb_program.svh
// memories are tb arrays; data memory is 16 words, indexed by address[5:2]
// outputs are sampled on the falling edge, inputs driven 2 ns after the rising edge
`timescale 1ns/1ps

module simple_rv_core_tb;
  import rv_pkg::*;

  localparam word_t nop_inst = 32'h0000_0013;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    logic      rd_write;
    reg_addr_t rd;
    word_t     rd_data;
    word_t     next_pc;
  } program_entry_t;

  logic      clock;
  logic      arst_n;
  logic      stall;
  word_t     inst;
  word_t     inst_address;
  word_t     data_mem_address;
  word_t     data_mem_write_data;
  word_t     data_mem_read_data;
  logic      data_mem_write_enable;
  logic      retire_valid;
  word_t     retire_pc;
  logic      retire_rd_write;
  reg_addr_t retire_rd;
  word_t     retire_rd_data;

  program_entry_t program_q [$];
  word_t          dmem [16];
  logic [15:0]    lfsr;
  int unsigned    check_count;
  int unsigned    error_count;
  int unsigned    cycle_count;
  int unsigned    retired_count;

  simple_rv_core simple_rv_core_i (
    .clock                 (clock),
    .arst_n                (arst_n),
    .inst_address          (inst_address),
    .inst                  (inst),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .data_mem_write_enable (data_mem_write_enable),
    .data_mem_read_data    (data_mem_read_data),
    .stall                 (stall),
    .retire_valid          (retire_valid),
    .retire_pc             (retire_pc),
    .retire_rd_write       (retire_rd_write),
    .retire_rd             (retire_rd),
    .retire_rd_data        (retire_rd_data)
  );

  // --------------------------------------------------------------------------
  // instruction encoders and program table
  // --------------------------------------------------------------------------
  function automatic word_t r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] funct3,
                                   input reg_addr_t rd);
    return {funct7, rs2, rs1, funct3, rd, op_reg};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] funct3, input reg_addr_t rd,
                                   input opcode_t opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                   input opcode_t opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic add_entry(input word_t pc, input word_t inst_word, input logic rd_write,
                           input reg_addr_t rd, input word_t rd_data, input word_t next_pc);
    program_q.push_back(program_entry_t'{pc, inst_word, rd_write, rd, rd_data, next_pc});
  endtask

  `include "tb_program.svh"

  function automatic word_t fetch(input word_t address);
    foreach (program_q[i]) begin
      if (program_q[i].pc == address) begin
        return program_q[i].inst;
      end
    end
    return nop_inst;
  endfunction

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // --------------------------------------------------------------------------
  // checks and reporting
  // --------------------------------------------------------------------------
  task automatic compare_word(input word_t actual, input word_t expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_reg_addr(input reg_addr_t actual, input reg_addr_t expected,
                                input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error %0t: %s is x%0d, expected x%0d", $time, what, actual, expected);
    end
  endtask

  task automatic expect_bit(input logic actual, input logic expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("checks %0d, errors %0d, retired %0d of %0d", check_count, error_count,
             retired_count, program_q.size());
    if (!timed_out && error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // clock, memories, stimulus
  // --------------------------------------------------------------------------
  initial begin : clock_gen
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  assign data_mem_read_data = dmem[data_mem_address[5:2]];

  always @(posedge clock) begin : data_mem_write
    if (data_mem_write_enable) begin
      dmem[data_mem_address[5:2]] <= data_mem_write_data;
    end
  end

  task automatic drive_inputs;
    logic bit_a;
    logic bit_b;
    lfsr  = lfsr_next(lfsr);
    bit_a = lfsr[0];
    lfsr  = lfsr_next(lfsr);
    bit_b = lfsr[0];
    stall = bit_a & bit_b;
    inst  = fetch(inst_address);
  endtask

  initial begin : stimulus
    arst_n        = 1'b0;
    stall         = 1'b1;
    inst          = nop_inst;
    lfsr          = 16'd22181;
    check_count   = 0;
    error_count   = 0;
    retired_count = 0;
    for (int i = 0; i < 16; i++) begin
      dmem[i] = 32'hDA7A_0000 ^ word_t'(i * 4);
    end
    load_program();
    repeat (5) @(posedge clock);
    #2;
    arst_n = 1'b1;
    drive_inputs();
    forever begin
      @(posedge clock);
      #2;
      drive_inputs();
    end
  end

  // --------------------------------------------------------------------------
  // retire checks, one table entry per retired instruction
  // --------------------------------------------------------------------------
  initial begin : retire_check
    word_t          expect_pc;
    logic           expect_we;
    program_entry_t entry;
    expect_pc = initial_pc;
    wait (arst_n === 1'b1);
    while (retired_count < program_q.size()) begin
      @(negedge clock);
      compare_word(inst_address, expect_pc, "inst_address");
      expect_bit(retire_valid, !stall, "retire_valid");
      expect_we = !stall && inst[6:0] == op_store;
      expect_bit(data_mem_write_enable, expect_we, "data_mem_write_enable");
      if (retire_valid) begin
        entry = program_q[retired_count];
        compare_word(retire_pc, entry.pc, "retire_pc");
        expect_bit(retire_rd_write, entry.rd_write, "retire_rd_write");
        if (entry.rd_write) begin
          check_reg_addr(retire_rd, entry.rd, "retire_rd");
          compare_word(retire_rd_data, entry.rd_data, "retire_rd_data");
        end
        // the program only stores and loads word 2, the store writes x13
        if (inst[6:0] == op_load || inst[6:0] == op_store) begin
          compare_word(data_mem_address, 32'h0000_0008, "data_mem_address");
        end
        if (inst[6:0] == op_store) begin
          compare_word(data_mem_write_data, 32'h0000_0807, "data_mem_write_data");
        end
        expect_pc = entry.next_pc;
        retired_count++;
      end
    end
    @(negedge clock);
    compare_word(inst_address, expect_pc, "inst_address after last instruction");
    compare_word(dmem[2], 32'h0000_0807, "data memory word 2");
    finish_run(1'b0);
  end

  always @(posedge clock) begin : watchdog
    cycle_count++;
    if (cycle_count > program_q.size() * 4 + 20) begin
      $display("timeout: the program did not complete within %0d cycles", cycle_count - 1);
      finish_run(1'b1);
    end
  end

  initial begin : watchdog_init
    cycle_count = 0;
  end

endmodule

// ==== simple_rv.f ====
+incdir+verif
common/rv_pkg.sv
common/ctrl_if.sv
rtl/alu.sv
rtl/regfile.sv
rtl/immediate_generator.sv
singlecycle_datapath/singlecycle_datapath.sv
rtl/singlecycle_control.sv
rtl/simple_rv_core.sv
verif/simple_rv_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the simple_rv core testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= simple_rv_core_tb
FILELIST  ?= simple_rv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
